// File: hw/dc_macros.svh
`ifndef DC_MACROS_SVH
`define DC_MACROS_SVH

// geometry of the data cache array
`define DC_WAYS   4
`define DC_SETS   64
`define DC_WORDS  4   // words per line
`define DC_WORD_W 32
`define DC_ADDR_W 16  // byte address
`define DC_TAG_W  6

`endif

// File: hw/dc_pkg.sv
`include "dc_macros.svh"

package dc_pkg;

  typedef logic [`DC_TAG_W-1:0]            dc_tag_t;
  typedef logic [$clog2(`DC_SETS)-1:0]     dc_index_t;
  typedef logic [$clog2(`DC_WORDS)-1:0]    dc_offset_t;
  typedef logic [$clog2(`DC_WAYS)-1:0]     dc_way_t;
  typedef logic [`DC_WORD_W-1:0]           dc_word_t;
  typedef logic [`DC_WORD_W/8-1:0]         dc_sel_t;
  typedef logic [`DC_WAYS-1:0]             dc_hit_t;

  typedef struct packed {
    dc_tag_t                           tag;
    dc_index_t                         index;
    dc_offset_t                        offset;
    logic [$clog2(`DC_WORD_W/8)-1:0]   byte_off;  // ignored
  } dc_addr_t;

  typedef struct packed {
    logic    valid;
    dc_tag_t tag;
  } dc_tag_entry_t;

  // rank 0 most recent, top rank is the victim
  typedef dc_way_t [`DC_WAYS-1:0] dc_ranks_t;

  typedef dc_word_t [`DC_WORDS-1:0] dc_line_t;

  typedef struct packed {
    logic      valid;
    dc_tag_t   tag;
    dc_index_t index;
    dc_line_t  line;
  } dc_fill_t;

endpackage

// File: hw/wb_pkg.sv
`include "dc_macros.svh"

package wb_pkg;

  // wishbone classic, master to slave
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`DC_ADDR_W-1:0]   adr;
    logic [`DC_WORD_W/8-1:0] sel;
    logic [`DC_WORD_W-1:0]   dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic                  err;  // miss
    logic [`DC_WORD_W-1:0] dat;
  } wb_rsp_t;

endpackage

// File: hw/dc_ram.sv
`timescale 1ns/1ps

module dc_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  logic [$clog2(depth)-1:0] rd_addr,
  output payload_t                 rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(depth)-1:0] wr_addr,
  input  payload_t                 wr_data
);

  payload_t                 mem [depth];
  logic [$clog2(depth)-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (rst)
      addr_q <= '0;
    else if (rd_en)
      addr_q <= rd_addr;  // held otherwise
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // write first, the registered address sees the new word
  assign rd_data = mem[addr_q];

endmodule

// File: hw/dc_word_bank.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_word_bank
  import dc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dc_index_t index,
  input  logic      rd_en,
  output dc_word_t  rd_data,
  input  logic      hit_we,
  input  dc_sel_t   sel,
  input  dc_word_t  wdata,
  input  logic      fill_we,
  input  dc_word_t  fill_word
);

  dc_index_t index_q;
  dc_sel_t   sel_q;
  dc_word_t  wdata_q;
  dc_word_t  merged;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      index_q <= index;
      sel_q   <= sel;
      wdata_q <= wdata;
    end
  end

  // read-modify-write of the old word
  always_comb begin
    for (int b = 0; b < $bits(dc_sel_t); b++)
      merged[8*b +: 8] = sel_q[b] ? wdata_q[8*b +: 8] : rd_data[8*b +: 8];
  end

  dc_ram #(
    .payload_t(dc_word_t),
    .depth    (`DC_SETS)
  ) u_ram (
    .clk,
    .rst,
    .rd_en,
    .rd_addr(index),
    .rd_data,
    .wr_en  (hit_we || fill_we),
    .wr_addr(index_q),
    .wr_data(fill_we ? fill_word : merged)
  );

  // controller never mixes a hit write and a fill in one cycle
  a_one_writer: assert property (@(posedge clk) disable iff (rst)
    !(hit_we && fill_we));

endmodule

// File: hw/dc_tag_array.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_tag_array
  import dc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dc_index_t index,
  input  logic      rd_en,
  input  dc_tag_t   tag,
  output dc_hit_t   hit,
  input  logic      wr_en,
  input  dc_way_t   wr_way,
  input  dc_tag_t   wr_tag,
  input  logic      sweep_we,
  input  dc_index_t sweep_index
);

  dc_tag_entry_t rd_entry [`DC_WAYS];
  dc_tag_entry_t wr_entry;
  dc_index_t     index_q;
  dc_index_t     wr_index;
  dc_tag_t       tag_q;
  logic          looked_q;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      index_q <= index;
      tag_q   <= tag;   // compare tag
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      looked_q <= 1'b0;
    else
      looked_q <= rd_en;
  end

  // sweep clears every way of a set at once
  assign wr_index = sweep_we ? sweep_index : index_q;
  assign wr_entry = sweep_we ? '0 : dc_tag_entry_t'{valid: 1'b1, tag: wr_tag};

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dc_ram #(
      .payload_t(dc_tag_entry_t),
      .depth    (`DC_SETS)
    ) u_ram (
      .clk,
      .rst,
      .rd_en,
      .rd_addr(index),
      .rd_data(rd_entry[w]),
      .wr_en  (sweep_we || (wr_en && wr_way == dc_way_t'(w))),
      .wr_addr(wr_index),
      .wr_data(wr_entry)
    );
    assign hit[w] = rd_entry[w].valid && rd_entry[w].tag == tag_q;
  end

  // a line lives in one way only, fills reuse the way that holds it
  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    looked_q |-> $onehot0(hit));

endmodule

// File: hw/dc_lru.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_lru
  import dc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dc_index_t index,
  input  logic      rd_en,
  input  dc_hit_t   hit,
  output dc_way_t   victim,
  input  logic      touch_en,
  input  dc_way_t   touch_way,
  input  logic      sweep_we,
  input  dc_index_t sweep_index
);

  dc_ranks_t ranks;
  dc_ranks_t touched;
  dc_ranks_t seed;
  dc_index_t index_q;
  logic      looked_q;

  function automatic logic is_perm(dc_ranks_t r);
    logic [`DC_WAYS-1:0] seen;
    seen = '0;
    for (int i = 0; i < `DC_WAYS; i++)
      seen[r[i]] = 1'b1;
    return &seen;
  endfunction

  always_ff @(posedge clk) begin
    if (rd_en)
      index_q <= index;
  end

  always_ff @(posedge clk) begin
    if (rst)
      looked_q <= 1'b0;
    else
      looked_q <= rd_en;
  end

  always_comb begin
    victim = '0;
    for (int i = 0; i < `DC_WAYS; i++)
      if (ranks[i] == dc_way_t'(`DC_WAYS - 1))
        victim = dc_way_t'(i);
  end

  // touched way to the front, the ones ahead of it slide back by one
  always_comb begin
    touched = ranks;
    for (int i = 0; i < `DC_WAYS; i++) begin
      if (dc_way_t'(i) == touch_way)
        touched[i] = '0;
      else if (ranks[i] < ranks[touch_way])
        touched[i] = ranks[i] + 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < `DC_WAYS; i++)
      seed[i] = dc_way_t'(i);
  end

  dc_ram #(
    .payload_t(dc_ranks_t),
    .depth    (`DC_SETS)
  ) u_ram (
    .clk,
    .rst,
    .rd_en,
    .rd_addr(index),
    .rd_data(ranks),
    .wr_en  (sweep_we || touch_en),
    .wr_addr(sweep_we ? sweep_index : index_q),
    .wr_data(sweep_we ? seed : touched)
  );

  a_ranks_perm: assert property (@(posedge clk) disable iff (rst)
    looked_q |-> is_perm(ranks));

  // when the line is present the touch lands on its way
  a_touch_hit: assert property (@(posedge clk) disable iff (rst)
    (touch_en && |hit) |-> hit[touch_way]);

endmodule

// File: hw/dc_ctrl.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_ctrl
  import dc_pkg::*, wb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  wb_req_t              wb_req,
  output logic                 wb_rsp_ack,
  output logic                 wb_rsp_err,
  input  dc_fill_t             fill,
  output logic                 fill_ready,
  output dc_index_t            index,
  output dc_tag_t              tag,
  output logic                 rd_en,
  output dc_offset_t           offset,
  output dc_sel_t              sel,
  output dc_word_t             wdata,
  output logic [`DC_WORDS-1:0] bank_hit_we,
  output logic                 fill_we,
  output dc_way_t              fill_way,
  output dc_line_t             fill_line,
  output logic                 touch_en,
  output dc_way_t              touch_way,
  input  dc_hit_t              hit,
  input  dc_way_t              victim,
  output logic                 sweep_we,
  output dc_index_t            sweep_index
);

  typedef enum logic [2:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_LOOK,   // ram outputs valid, hit known
    ST_RESP,
    ST_FILL
  } state_t;

  state_t    state;
  dc_index_t sweep_cnt;
  dc_fill_t  fill_q;
  logic      we_q;
  dc_addr_t  req_addr;
  logic      take_fill;
  logic      take_wb;
  logic      any_hit;
  dc_way_t   hit_way;
  dc_way_t   way_sel;

  assign req_addr   = dc_addr_t'(wb_req.adr);
  assign take_fill  = state == ST_IDLE && fill.valid;  // fills go first
  assign take_wb    = state == ST_IDLE && !fill.valid && wb_req.cyc && wb_req.stb;
  assign fill_ready = state == ST_IDLE;

  assign rd_en = take_fill || take_wb;
  assign index = take_fill ? fill.index : req_addr.index;
  // during the fill the held tag goes back to the tag array for the write
  assign tag   = take_fill ? fill.tag : (state == ST_FILL) ? fill_q.tag : req_addr.tag;
  assign sel   = wb_req.sel;
  assign wdata = wb_req.dat;

  always_comb begin
    hit_way = '0;
    for (int i = 0; i < `DC_WAYS; i++)
      if (hit[i])
        hit_way = dc_way_t'(i);
  end

  assign any_hit = |hit;
  assign way_sel = any_hit ? hit_way : victim;  // refill in place

  always_comb begin
    for (int w = 0; w < `DC_WORDS; w++)
      bank_hit_we[w] = state == ST_LOOK && we_q && any_hit && offset == dc_offset_t'(w);
  end

  assign fill_we   = state == ST_FILL;
  assign fill_way  = way_sel;
  assign fill_line = fill_q.line;
  assign touch_en  = (state == ST_LOOK && any_hit) || state == ST_FILL;
  assign touch_way = way_sel;

  assign sweep_we    = state == ST_SWEEP;
  assign sweep_index = sweep_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_SWEEP;
      sweep_cnt  <= '0;
      wb_rsp_ack <= 1'b0;
      wb_rsp_err <= 1'b0;
    end else begin
      wb_rsp_ack <= 1'b0;
      wb_rsp_err <= 1'b0;
      case (state)
        ST_SWEEP: begin
          sweep_cnt <= sweep_cnt + 1'b1;
          if (sweep_cnt == dc_index_t'(`DC_SETS - 1))
            state <= ST_IDLE;
        end
        ST_IDLE: begin
          if (take_fill)
            state <= ST_FILL;
          else if (take_wb)
            state <= ST_LOOK;
        end
        ST_LOOK: begin
          wb_rsp_ack <= any_hit;
          wb_rsp_err <= !any_hit;  // nothing behind us to fetch from
          state      <= ST_RESP;
        end
        ST_RESP: state <= ST_IDLE;
        ST_FILL: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request and fill capture at the lookup edge
  always_ff @(posedge clk) begin
    if (take_fill)
      fill_q <= fill;
    if (take_wb) begin
      we_q   <= wb_req.we;
      offset <= req_addr.offset;
    end
  end

  // one response per access, exactly one of ack and err, one cycle long
  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
    (wb_rsp_ack || wb_rsp_err) |->
      !(wb_rsp_ack && wb_rsp_err) ##1 !(wb_rsp_ack || wb_rsp_err));

endmodule

// File: hw/dc_top.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_top
  import dc_pkg::*, wb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp,
  input  dc_fill_t fill,
  output logic     fill_ready
);

  dc_index_t            index;
  dc_tag_t              tag;
  logic                 rd_en;
  dc_offset_t           offset;
  dc_sel_t              sel;
  dc_word_t             wdata;
  logic [`DC_WORDS-1:0] bank_hit_we;
  logic                 fill_we;
  dc_way_t              fill_way;
  dc_line_t             fill_line;
  logic                 touch_en;
  dc_way_t              touch_way;
  dc_hit_t              hit;
  dc_way_t              victim;
  logic                 sweep_we;
  dc_index_t            sweep_index;
  dc_word_t             bank_word [`DC_WAYS][`DC_WORDS];
  dc_word_t             rd_word;

  dc_ctrl u_ctrl (
    .clk, .rst, .wb_req,
    .wb_rsp_ack(wb_rsp.ack),
    .wb_rsp_err(wb_rsp.err),
    .fill, .fill_ready, .index, .tag, .rd_en, .offset, .sel, .wdata,
    .bank_hit_we, .fill_we, .fill_way, .fill_line, .touch_en, .touch_way,
    .hit, .victim, .sweep_we, .sweep_index
  );

  dc_tag_array u_tags (
    .clk, .rst, .index, .rd_en, .tag, .hit,
    .wr_en (fill_we),
    .wr_way(fill_way),
    .wr_tag(tag),
    .sweep_we, .sweep_index
  );

  dc_lru u_lru (
    .clk, .rst, .index, .rd_en, .hit, .victim, .touch_en, .touch_way,
    .sweep_we, .sweep_index
  );

  for (genvar v = 0; v < `DC_WAYS; v++) begin : g_way
    for (genvar w = 0; w < `DC_WORDS; w++) begin : g_word
      dc_word_bank u_bank (
        .clk, .rst, .index, .rd_en,
        .rd_data  (bank_word[v][w]),
        .hit_we   (bank_hit_we[w] && hit[v]),
        .sel, .wdata,
        .fill_we  (fill_we && fill_way == dc_way_t'(v)),
        .fill_word(fill_line[w])
      );
    end
  end

  // hit is one-hot, so an and-or mux picks the way
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < `DC_WAYS; i++)
      if (hit[i])
        rd_word = rd_word | bank_word[i][offset];
  end

  assign wb_rsp.dat = rd_word;

endmodule

// File: dv/dc_tb.sv
`timescale 1ns/1ps
`include "dc_macros.svh"

module dc_tb
  import dc_pkg::*, wb_pkg::*;
();

  localparam int timeout_cycles = 200;  // covers the reset sweep

  logic     clk;
  logic     rst;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  dc_fill_t fill;
  logic     fill_ready;

  int          errors;
  logic        hung;
  logic [31:0] rand_state;
  dc_tag_t     set_tags [5];

  // reference model per set and way
  logic     m_valid [`DC_SETS][`DC_WAYS];
  dc_tag_t  m_tag   [`DC_SETS][`DC_WAYS];
  dc_line_t m_line  [`DC_SETS][`DC_WAYS];
  dc_way_t  m_rank  [`DC_SETS][`DC_WAYS];

  dc_top i_dut (.clk, .rst, .wb_req, .wb_rsp, .fill, .fill_ready);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic dc_line_t random_line();
    dc_line_t line;
    for (int w = 0; w < `DC_WORDS; w++)
      line[w] = next_rand();
    return line;
  endfunction

  function automatic int find_way(dc_index_t set, dc_tag_t tag);
    int way;
    way = -1;
    for (int w = 0; w < `DC_WAYS; w++)
      if (m_valid[set][w] && m_tag[set][w] == tag)
        way = w;
    return way;
  endfunction

  function automatic int lru_victim(dc_index_t set);
    int way;
    way = 0;
    for (int w = 0; w < `DC_WAYS; w++)
      if (m_rank[set][w] == 2'd3)
        way = w;
    return way;
  endfunction

  // way to rank 0 and the more recent ones age by one
  task automatic promote_way(dc_index_t set, int way);
    dc_way_t old;
    old = m_rank[set][way];
    for (int w = 0; w < `DC_WAYS; w++)
      if (m_rank[set][w] < old)
        m_rank[set][w] = m_rank[set][w] + 2'd1;
    m_rank[set][way] = 2'd0;
  endtask

  task automatic fill_line(input dc_tag_t tag, input dc_index_t set, input dc_line_t line);
    int way;
    int cnt;
    if (!hung) begin
      cnt = 0;
      while (!fill_ready && cnt < timeout_cycles) begin
        @(negedge clk);
        cnt++;
      end
      if (!fill_ready) begin
        hung = 1'b1;
        $display("timeout: fill_ready never rose for set %h", set);
      end else begin
        fill.valid = 1'b1;
        fill.tag   = tag;
        fill.index = set;
        fill.line  = line;
        @(negedge clk);
        fill.valid = 1'b0;
        assert (!fill_ready) else begin
          errors++;
          $display("[FAIL] fill_ready after an accepted fill: got %h expected %h",
                   fill_ready, 1'b0);
        end
        way = find_way(set, tag);
        if (way < 0)
          way = lru_victim(set);  // absent so evict the victim
        m_valid[set][way] = 1'b1;
        m_tag[set][way]   = tag;
        m_line[set][way]  = line;
        promote_way(set, way);
      end
    end
  endtask

  task automatic wb_access(input logic we, input dc_tag_t tag, input dc_index_t set,
                           input dc_offset_t off, input dc_sel_t sel, input dc_word_t dat);
    int          way;
    int          cnt;
    logic [15:0] adr;
    logic        got_ack;
    logic        got_err;
    dc_word_t    got_dat;
    dc_word_t    word;
    if (!hung) begin
      way = find_way(set, tag);
      adr = {tag, set, off, 2'b00};
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.sel = sel;
      wb_req.dat = dat;
      cnt = 0;
      @(negedge clk);
      while (!(wb_rsp.ack || wb_rsp.err) && cnt < timeout_cycles) begin
        @(negedge clk);
        cnt++;
      end
      got_ack = wb_rsp.ack;
      got_err = wb_rsp.err;
      got_dat = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      if (!(got_ack || got_err)) begin
        hung = 1'b1;
        $display("timeout: no ack or err for the access at %h", adr);
      end else begin
        assert (got_ack == (way >= 0)) else begin
          errors++;
          $display("[FAIL] wb_rsp.ack at %h: got %h expected %h", adr, got_ack, way >= 0);
        end
        assert (got_err == (way < 0)) else begin
          errors++;
          $display("[FAIL] wb_rsp.err at %h: got %h expected %h", adr, got_err, way < 0);
        end
        if (way >= 0) begin
          word = m_line[set][way][off];
          if (!we) begin
            assert (got_dat == word) else begin
              errors++;
              $display("[FAIL] wb_rsp.dat at %h: got %h expected %h", adr, got_dat, word);
            end
          end
          for (int b = 0; b < `DC_WORD_W / 8; b++)
            if (we && sel[b])
              word[8*b +: 8] = dat[8*b +: 8];
          m_line[set][way][off] = word;
          promote_way(set, way);
        end
        @(negedge clk);
        assert (!wb_rsp.ack && !wb_rsp.err) else begin
          errors++;
          $display("[FAIL] {wb_rsp.ack, wb_rsp.err} after the response at %h: got %h expected %h",
                   adr, {wb_rsp.ack, wb_rsp.err}, 2'b00);
        end
      end
    end
  endtask

  task automatic read_set_tags(input dc_index_t set);
    for (int k = 0; k < 5; k++)
      for (int w = 0; w < `DC_WORDS; w++)
        wb_access(1'b0, set_tags[k], set, dc_offset_t'(w), '0, '0);
  endtask

  initial begin
    logic [31:0] r;
    dc_tag_t     ftag [6];
    dc_index_t   fset [6];
    dc_tag_t     evicted;
    dc_tag_t     refill;
    int          k;
    errors     = 0;
    hung       = 1'b0;
    rand_state = 32'd33418;
    rst        = 1'b1;
    wb_req     = '0;
    fill       = '0;
    for (int s = 0; s < `DC_SETS; s++)
      for (int w = 0; w < `DC_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_line[s][w]  = '0;
        m_rank[s][w]  = dc_way_t'(w);  // sweep seed
      end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // empty cache so every read misses
    repeat (8) begin
      r = next_rand();
      wb_access(1'b0, r[31:26], r[25:20], r[19:18], '0, '0);
    end

    // random fills in the lower half of the sets and read back
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      ftag[i] = r[31:26];
      fset[i] = {1'b0, r[25:21]};
      fill_line(ftag[i], fset[i], random_line());
    end
    for (int i = 0; i < 6; i++)
      for (int w = 0; w < `DC_WORDS; w++)
        wb_access(1'b0, ftag[i], fset[i], dc_offset_t'(w), '0, '0);

    // byte-select writes, each followed by a read
    repeat (12) begin
      r = next_rand();
      k = int'(r[31:29]) % 6;
      wb_access(1'b1, ftag[k], fset[k], r[28:27], r[26:23], next_rand());
      wb_access(1'b0, ftag[k], fset[k], r[28:27], '0, '0);
    end

    // five tags into set 63 with reads in between
    evicted = '0;
    for (int i = 0; i < 5; i++) begin
      set_tags[i] = dc_tag_t'(9 * i + 3);
      if (i == 4)
        evicted = m_tag[63][lru_victim(6'd63)];
      fill_line(set_tags[i], 6'd63, random_line());
      r = next_rand();
      wb_access(1'b0, set_tags[int'(r[31:29]) % (i + 1)], 6'd63, r[27:26], '0, '0);
    end
    read_set_tags(6'd63);

    // refill a present line that is not the victim
    refill = '0;
    for (int w = 0; w < `DC_WAYS; w++)
      if (m_rank[63][w] == 2'd2)
        refill = m_tag[63][w];
    fill_line(refill, 6'd63, random_line());
    read_set_tags(6'd63);

    // writes that miss leave the set alone
    wb_access(1'b1, evicted, 6'd63, 2'd1, 4'hf, next_rand());
    wb_access(1'b1, 6'h3f, 6'd63, 2'd2, 4'h5, next_rand());
    read_set_tags(6'd63);

    $display("check errors: %0d, timeouts: %0d", errors, hung);
    if (errors == 0 && !hung) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/dc_pkg.sv
hw/wb_pkg.sv
hw/dc_ram.sv
hw/dc_word_bank.sv
hw/dc_tag_array.sv
hw/dc_lru.sv
hw/dc_ctrl.sv
hw/dc_top.sv
dv/dc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dc_tb \
  -f project.f --Mdir obj_dir -o dc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$log"; then
  exit 1
fi
exit 0
